//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_writeback
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "no pass message in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
wb_pkg.sv
wb_flow_ctrl.sv
wb_result_router.sv
wb_commit.sv
writeback_stage.sv
wb_asserts.sv
tb_writeback.sv

//--- tb_writeback.sv
`timescale 1ns/1ps

module tb_writeback;

    localparam int num_slots       = 4;
    localparam int data_w          = 64;
    localparam int clk_period      = 8;
    localparam int reset_cycles    = 4;
    localparam int directed_cycles = 16;
    localparam int num_random      = 400;
    localparam int run_cycles      = reset_cycles + directed_cycles + num_random;

    logic                             clk;
    logic                             reset;
    logic                             valid_in;
    logic [36:0]                      uop_ctrl;
    logic [31:0]                      eip_in;
    logic [31:0]                      br_fip;
    logic [31:0]                      br_fip_p1;
    logic                             br_taken;
    logic                             br_correct;
    logic                             ie_in;
    logic [3:0]                       ie_type;
    logic                             interrupt_in;
    logic                             idtr_servicing;
    logic                             instr_is_idtr_orig;
    logic                             wbaq_full;
    logic [num_slots-1:0][data_w-1:0] slot_data;
    logic [num_slots-1:0][31:0]       slot_dest;
    logic [num_slots-1:0]             slot_is_reg;
    logic [num_slots-1:0]             slot_is_seg;
    logic [num_slots-1:0]             slot_is_mem;
    logic [num_slots-1:0]             slot_wb;
    logic [1:0]                       inp_size;
    logic [3:0]                       mem_size_ovr;
    logic                             valid_out;
    logic                             stall;
    logic                             mem_ld;
    logic [num_slots-1:0]             reg_ld;
    logic [num_slots-1:0]             seg_ld;
    logic [num_slots-1:0][data_w-1:0] res;
    logic [1:0]                       ressize;
    logic [3*num_slots-1:0]           reg_addr;
    logic [3*num_slots-1:0]           seg_addr;
    logic [data_w-1:0]                mem_data;
    logic [31:0]                      mem_addr;
    logic [1:0]                       memsize;
    logic [31:0]                      new_fip_e;
    logic [31:0]                      new_fip_o;
    logic [31:0]                      new_eip;
    logic                             is_resteer;
    logic                             final_ie_val;
    logic [3:0]                       final_ie_type;
    logic                             instr_is_final_wb;
    logic                             halts;
    logic                             halt_flop;

    logic        ie_exp_val;
    logic [3:0]  ie_exp_type;

    writeback_stage #(
        .num_slots (num_slots),
        .data_w    (data_w)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // quiet micro-op, later nba in the same step overrides fields
    task automatic idle_inputs();
        valid_in           <= 1'b0;
        uop_ctrl           <= '0;
        eip_in             <= 32'h0000_1000;
        br_fip             <= 32'h0000_2000;
        br_fip_p1          <= 32'h0000_2010;
        br_taken           <= 1'b0;
        br_correct         <= 1'b1;
        ie_in              <= 1'b0;
        ie_type            <= 4'h0;
        interrupt_in       <= 1'b0;
        idtr_servicing     <= 1'b0;
        instr_is_idtr_orig <= 1'b0;
        wbaq_full          <= 1'b0;
        slot_data          <= '0;
        slot_dest          <= '0;
        slot_is_reg        <= '0;
        slot_is_seg        <= '0;
        slot_is_mem        <= '0;
        slot_wb            <= '0;
        inp_size           <= 2'd1;
        mem_size_ovr       <= 4'h0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        idle_inputs();
    endtask

    task automatic random_uop();
        logic [31:0]                      r;
        logic [31:0]                      r2;
        logic [31:0]                      r3;
        logic [31:0]                      fip;
        logic [num_slots-1:0][data_w-1:0] data_v;
        logic [num_slots-1:0][31:0]       dest_v;
        r   = $urandom;
        r2  = $urandom;
        r3  = $urandom;
        fip = $urandom;
        r2[9] = &r[28:25];  // rare halt
        for (int i = 0; i < num_slots; i++) begin
            data_v[i] = {$urandom, $urandom};
            dest_v[i] = $urandom;
        end
        valid_in           <= |r[1:0];
        br_taken           <= r[2];
        br_correct         <= r[3] | r[4];
        ie_in              <= &r[7:5];
        interrupt_in       <= &r[10:8];
        idtr_servicing     <= &r[12:11];
        instr_is_idtr_orig <= &r[14:13];
        wbaq_full          <= r[15];
        ie_type            <= r[19:16];
        inp_size           <= r[21:20];
        mem_size_ovr       <= r[22] ? 4'b0001 << r[24:23] : 4'b0000;
        uop_ctrl           <= {r[29] & r[30], r[31] & r[30], 2'b00, r[29] & r[31], r2};
        eip_in             <= r3;
        br_fip             <= fip;
        br_fip_p1          <= fip + 32'h10;
        slot_data          <= data_v;
        slot_dest          <= dest_v;
        slot_is_reg        <= r3[3:0];
        slot_is_seg        <= r3[7:4];
        slot_is_mem        <= r3[11:8] & r3[15:12];
        slot_wb            <= r3[19:16] | r3[23:20];
    endtask

    task automatic run_directed();
        next_cycle();  // plain register and segment writes
        valid_in    <= 1'b1;
        slot_is_reg <= 4'b0101;
        slot_is_seg <= 4'b0010;
        slot_wb     <= 4'b0111;
        next_cycle();  // memory write blocked by full queue
        valid_in    <= 1'b1;
        slot_is_reg <= 4'b0001;
        slot_is_mem <= 4'b0100;
        slot_wb     <= 4'b0101;
        wbaq_full   <= 1'b1;
        next_cycle();
        valid_in           <= 1'b1;
        slot_is_reg        <= 4'b0001;
        slot_is_mem        <= 4'b0100;
        slot_wb            <= 4'b0101;
        wbaq_full          <= 1'b1;
        instr_is_idtr_orig <= 1'b1;
        next_cycle();  // far jump, taken
        valid_in     <= 1'b1;
        uop_ctrl     <= 37'h1 << 35;
        br_taken     <= 1'b1;
        slot_data[0] <= 64'h0000_1234_8000_0040;
        slot_is_mem  <= 4'b0010;
        slot_wb      <= 4'b0010;
        next_cycle();
        valid_in     <= 1'b1;
        uop_ctrl     <= 37'h1 << 32;
        slot_data[0] <= 64'hffff_0028_0000_1000;
        mem_size_ovr <= 4'b1000;
        next_cycle();  // mispredict with odd fetch line
        valid_in   <= 1'b1;
        br_taken   <= 1'b1;
        br_correct <= 1'b0;
        br_fip     <= 32'h0000_2f18;
        br_fip_p1  <= 32'h0000_2f28;
        next_cycle();
        valid_in       <= 1'b1;
        ie_in          <= 1'b1;
        ie_type        <= 4'h6;
        idtr_servicing <= 1'b1;
        next_cycle();
        valid_in     <= 1'b1;
        interrupt_in <= 1'b1;
        ie_type      <= 4'h2;
        next_cycle();  // committed halt
        valid_in <= 1'b1;
        uop_ctrl <= 37'h203;
        next_cycle();
        next_cycle();
        reset <= 1'b1;
        next_cycle();
        reset <= 1'b0;
    endtask

    initial begin
        void'($urandom(89800));
        reset = 1'b1;
        idle_inputs();
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        run_directed();
        repeat (num_random) begin
            @(posedge clk);
            random_uop();
        end
        next_cycle();
        repeat (2) @(posedge clk);  // idle cycle checked on both edges by now
        if (i_dut.i_asserts.err_count != 0) begin
            report_error("assertion failure in the last cycles");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // inputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (i_dut.i_asserts.err_count != 0) begin
            report_error("concurrent assertion in wb_asserts failed");
        end else if (!reset) begin
            ie_exp_val  = (ie_in | interrupt_in) & valid_in & ~idtr_servicing;
            ie_exp_type = (valid_in & ~idtr_servicing) ? {interrupt_in, ie_type[2:0]} : 4'h0;
            assert (final_ie_val == ie_exp_val && final_ie_type == ie_exp_type)
                else report_error($sformatf("final event %0b/%h, expected %0b/%h",
                    final_ie_val, final_ie_type, ie_exp_val, ie_exp_type));
        end
    end

    initial begin
        #((run_cycles + 50) * clk_period);
        $display("watchdog expired before the test sequence completed");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- wb_asserts.sv
`timescale 1ns/1ps

module wb_asserts #(
    parameter int num_slots = 4,
    parameter int data_w    = 64
) (
    input logic                              clk,
    input logic                              reset,
    input logic                              valid_in,
    input logic [36:0]                       uop_ctrl,
    input logic [31:0]                       eip_in,
    input logic [31:0]                       br_fip,
    input logic [31:0]                       br_fip_p1,
    input logic                              br_taken,
    input logic                              br_correct,
    input logic                              ie_in,
    input logic                              interrupt_in,
    input logic                              instr_is_idtr_orig,
    input logic                              wbaq_full,
    input logic [num_slots-1:0][data_w-1:0]  slot_data,
    input logic [num_slots-1:0][31:0]        slot_dest,
    input logic [num_slots-1:0]              slot_is_reg,
    input logic [num_slots-1:0]              slot_is_seg,
    input logic [num_slots-1:0]              slot_is_mem,
    input logic [num_slots-1:0]              slot_wb,
    input logic [1:0]                        inp_size,
    input logic [3:0]                        mem_size_ovr,
    input logic                              valid_out,
    input logic                              stall,
    input logic                              mem_ld,
    input logic [num_slots-1:0]              reg_ld,
    input logic [num_slots-1:0]              seg_ld,
    input logic [num_slots-1:0][data_w-1:0]  res,
    input logic [1:0]                        ressize,
    input logic [3*num_slots-1:0]            reg_addr,
    input logic [3*num_slots-1:0]            seg_addr,
    input logic [data_w-1:0]                 mem_data,
    input logic [31:0]                       mem_addr,
    input logic [1:0]                        memsize,
    input logic [31:0]                       new_fip_e,
    input logic [31:0]                       new_fip_o,
    input logic [31:0]                       new_eip,
    input logic                              is_resteer,
    input logic                              instr_is_final_wb,
    input logic                              halts,
    input logic                              halt_flop
);

    int err_count = 0;  // watched from the testbench

    logic                   far;
    logic                   mem_wr;
    logic                   exp_stall;
    logic                   exp_valid;
    logic [1:0]             exp_size;
    logic [31:0]            exp_fip_e;
    logic [31:0]            exp_fip_o;
    logic [31:0]            exp_eip;
    logic [3*num_slots-1:0] exp_addr;
    logic                   mem_found;
    logic [data_w-1:0]      exp_mem_data;
    logic [31:0]            exp_mem_addr;
    logic                   exp_final_wb;

    task automatic note_failure(input string msg);
        err_count++;
        $error("%s", msg);
    endtask

    assign far       = uop_ctrl[36] | uop_ctrl[35] | uop_ctrl[32];
    assign mem_wr    = |(slot_is_mem & slot_wb);
    assign exp_stall = wbaq_full & valid_in & mem_wr;
    assign exp_valid = valid_in & ((~exp_stall & ~(ie_in | interrupt_in)) | instr_is_idtr_orig);

    // override first, then far pointer, then decoded size
    always_comb begin
        casez (mem_size_ovr)
            4'b???1: exp_size = 2'd0;
            4'b??10: exp_size = 2'd1;
            4'b?100: exp_size = 2'd2;
            4'b1000: exp_size = 2'd3;
            default: exp_size = far ? 2'd2 : inp_size;
        endcase
    end

    // odd br_fip line means the next line is the even one
    assign exp_fip_e = br_fip[4] ? {br_fip_p1[31:4], 4'h0} : {br_fip[31:4], 4'h0};
    assign exp_fip_o = br_fip[4] ? {br_fip[31:4], 4'h0} : {br_fip_p1[31:4], 4'h0};
    assign exp_eip   = !br_taken ? eip_in : (far ? slot_data[0][31:0] : br_fip);

    always_comb begin
        exp_addr     = '0;
        mem_found    = 1'b0;
        exp_mem_data = '0;
        exp_mem_addr = '0;
        for (int i = 0; i < num_slots; i++) begin
            exp_addr[3*i +: 3] = slot_dest[i][2:0];
        end
        // search upward, first memory slot is the one written
        for (int i = 0; i < num_slots; i++) begin
            if (!mem_found && slot_is_mem[i] && slot_wb[i]) begin
                mem_found    = 1'b1;
                exp_mem_data = slot_data[i];
                exp_mem_addr = slot_dest[i];
            end
        end
    end

    assign exp_final_wb = valid_in &
        ((uop_ctrl[1] & uop_ctrl[0]) | (uop_ctrl[12] & instr_is_idtr_orig));

    a_loads: assert property (@(posedge clk) disable iff (reset)
        reg_ld == (slot_is_reg & slot_wb & {num_slots{exp_valid}}) &&
        seg_ld == (slot_is_seg & slot_wb & {num_slots{exp_valid}}))
        else note_failure("register or segment load enable mismatch");

    a_full_block: assert property (@(posedge clk) disable iff (reset)
        valid_in && wbaq_full && mem_wr && !instr_is_idtr_orig |-> reg_ld == '0 && seg_ld == '0)
        else note_failure("load enable active while address queue full");

    a_stall: assert property (@(posedge clk) disable iff (reset)
        stall == exp_stall && valid_out == exp_valid && mem_ld == (valid_in & mem_wr))
        else note_failure("stall, mem_ld or valid_out mismatch");

    a_stall_drop: assert property (@(posedge clk) disable iff (reset)
        stall && !instr_is_idtr_orig |-> !valid_out)
        else note_failure("valid_out high during stall");

    a_memsize: assert property (@(posedge clk) disable iff (reset)
        memsize == exp_size)
        else note_failure("memsize priority mismatch");

    a_far_sel: assert property (@(posedge clk) disable iff (reset)
        res[0] == (far ? {{(data_w-16){1'b0}}, slot_data[0][47:32]} : slot_data[0]))
        else note_failure("slot 0 result mismatch");

    a_routing: assert property (@(posedge clk) disable iff (reset)
        res[num_slots-1:1] == slot_data[num_slots-1:1] && ressize == inp_size &&
        reg_addr == exp_addr && seg_addr == exp_addr)
        else note_failure("result routing or register address mismatch");

    a_mem_port: assert property (@(posedge clk) disable iff (reset)
        mem_wr |-> mem_data == exp_mem_data && mem_addr == exp_mem_addr)
        else note_failure("memory data or address not from the lowest memory slot");

    a_fetch: assert property (@(posedge clk) disable iff (reset)
        new_fip_e == exp_fip_e && new_fip_o == exp_fip_o && new_eip == exp_eip &&
        is_resteer == (valid_in & exp_valid & ~br_correct))
        else note_failure("fetch line, new eip or resteer mismatch");

    a_commit_flags: assert property (@(posedge clk) disable iff (reset)
        instr_is_final_wb == exp_final_wb && halts == (uop_ctrl[9] & exp_valid))
        else note_failure("final writeback or halts mismatch");

    // sticky latch, set one cycle after a committed halt
    a_halt: assert property (@(posedge clk)
        !reset |=> halt_flop == $past(halt_flop || (uop_ctrl[9] && exp_valid)))
        else note_failure("halt latch mismatch");

    a_halt_reset: assert property (@(posedge clk)
        reset |=> !halt_flop)
        else note_failure("halt latch not cleared by reset");

endmodule

bind writeback_stage wb_asserts #(
    .num_slots (num_slots),
    .data_w    (data_w)
) i_asserts (.*);

//--- wb_commit.sv
`timescale 1ns/1ps

module wb_commit #(
    parameter int num_slots = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid_in,
    input  logic                 wbaq_full,
    input  logic                 instr_is_idtr_orig,
    input  logic                 idtr_servicing,
    input  logic [num_slots-1:0] reg_cand,
    input  logic [num_slots-1:0] seg_cand,
    input  logic [num_slots-1:0] mem_sel,
    input  logic                 ie_pending,
    input  logic [3:0]           ie_cause,
    input  logic                 halt_op,
    input  logic                 last_uop,
    input  logic                 idtr_last,
    output logic                 valid_out,
    output logic                 stall,
    output logic                 mem_ld,
    output logic [num_slots-1:0] reg_ld,
    output logic [num_slots-1:0] seg_ld,
    output logic                 final_ie_val,
    output logic [3:0]           final_ie_type,
    output logic                 instr_is_final_wb,
    output logic                 halts,
    output logic                 halt_flop
);

    import wb_pkg::*;

    halt_state_e halt_state;
    logic        normal_commit;
    logic        idtr_commit;
    logic        ie_report;

    // memory write pending this cycle
    assign mem_ld = valid_in & (|mem_sel);
    assign stall  = wbaq_full & mem_ld;  // address queue has no room

    // idtr originated uops retire even under stall or event
    assign normal_commit = valid_in & ~stall & ~ie_pending;
    assign idtr_commit   = valid_in & instr_is_idtr_orig;
    assign valid_out     = normal_commit | idtr_commit;

    assign reg_ld = reg_cand & {num_slots{valid_out}};
    assign seg_ld = seg_cand & {num_slots{valid_out}};

    // events are held back while the idtr handler runs
    assign ie_report     = valid_in & ~idtr_servicing;
    assign final_ie_val  = ie_pending & ie_report;
    assign final_ie_type = ie_cause & {4{ie_report}};

    assign instr_is_final_wb = valid_in & (last_uop | (idtr_last & instr_is_idtr_orig));

    assign halts = halt_op & valid_out;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halt_state <= HALT_RUN;
        end else if (halts) begin
            halt_state <= HALT_STOPPED;
        end
    end

    assign halt_flop = (halt_state == HALT_STOPPED);

endmodule

//--- wb_flow_ctrl.sv
`timescale 1ns/1ps

module wb_flow_ctrl (
    input  logic [wb_pkg::wb_uop_w-1:0]  uop_ctrl,
    input  logic                         valid_in,
    input  logic [wb_pkg::wb_addr_w-1:0] eip_in,
    input  logic [wb_pkg::wb_addr_w-1:0] br_fip,
    input  logic [wb_pkg::wb_addr_w-1:0] br_fip_p1,
    input  logic                         br_taken,
    input  logic                         br_correct,
    input  logic [wb_pkg::wb_addr_w-1:0] slot0_low,  // far target offset
    input  logic                         ie_in,
    input  logic [3:0]                   ie_type,
    input  logic                         interrupt_in,
    input  logic                         valid_out,
    output logic                         far_xfer,
    output logic                         halt_op,
    output logic                         last_uop,
    output logic                         idtr_last,
    output logic [wb_pkg::wb_addr_w-1:0] new_fip_e,
    output logic [wb_pkg::wb_addr_w-1:0] new_fip_o,
    output logic [wb_pkg::wb_addr_w-1:0] new_eip,
    output logic                         is_resteer,
    output logic                         ie_pending,
    output logic [3:0]                   ie_cause
);

    import wb_pkg::*;

    localparam int line_lsb = 4;  // 16 byte fetch lines

    logic [wb_addr_w-1:0] fip_line;
    logic [wb_addr_w-1:0] fip_p1_line;
    logic [wb_addr_w-1:0] target_eip;
    logic                 fip_odd;

    // control word decode
    assign far_xfer  = |(uop_ctrl & uop_far_bits);
    assign halt_op   = uop_ctrl[uop_halt_bit];
    assign last_uop  = (uop_ctrl & uop_last_bits) == uop_last_bits;
    assign idtr_last = uop_ctrl[uop_idtr_last_bit];

    // line aligned copies of both fetch addresses
    assign fip_line    = {br_fip[wb_addr_w-1:line_lsb], {line_lsb{1'b0}}};
    assign fip_p1_line = {br_fip_p1[wb_addr_w-1:line_lsb], {line_lsb{1'b0}}};
    assign fip_odd     = br_fip[line_lsb];

    always_comb begin
        if (fip_odd) begin
            new_fip_e = fip_p1_line;  // next line is the even one
            new_fip_o = fip_line;
        end else begin
            new_fip_e = fip_line;
            new_fip_o = fip_p1_line;
        end
    end

    // far jumps take the offset from slot 0
    assign target_eip = far_xfer ? slot0_low : br_fip;
    assign new_eip    = br_taken ? target_eip : eip_in;

    // redirect fetch on a committed mispredict
    assign is_resteer = valid_in & valid_out & ~br_correct;

    // exception and external interrupt merge
    assign ie_pending = ie_in | interrupt_in;
    assign ie_cause   = {interrupt_in, ie_type[2:0]};  // bit 3 flags interrupt

endmodule

//--- wb_pkg.sv
package wb_pkg;

    // datapath widths
    localparam int wb_data_w = 64;  // result slot
    localparam int wb_addr_w = 32;  // eip, fetch lines, memory address
    localparam int wb_uop_w  = 37;  // micro-op control word

    // control word fields
    // any far bit set means eip and cs load together
    localparam logic [wb_uop_w-1:0] uop_far_bits =
        (37'd1 << 36) | (37'd1 << 35) | (37'd1 << 32);
    localparam int uop_halt_bit = 9;
    localparam logic [wb_uop_w-1:0] uop_last_bits = 37'h3;  // both set on last uop
    localparam int uop_idtr_last_bit = 12;

    // memory access size codes
    localparam logic [1:0] msize_byte  = 2'd0;
    localparam logic [1:0] msize_word  = 2'd1;
    localparam logic [1:0] msize_dword = 2'd2;
    localparam logic [1:0] msize_qword = 2'd3;

    // sticky halt latch
    typedef enum logic {
        HALT_RUN,
        HALT_STOPPED
    } halt_state_e;

endpackage

//--- wb_result_router.sv
`timescale 1ns/1ps

module wb_result_router #(
    parameter int num_slots = 4,
    parameter int data_w    = wb_pkg::wb_data_w
) (
    input  logic [num_slots-1:0][data_w-1:0]            slot_data,
    input  logic [num_slots-1:0][wb_pkg::wb_addr_w-1:0] slot_dest,
    input  logic [num_slots-1:0]                        slot_is_reg,
    input  logic [num_slots-1:0]                        slot_is_seg,
    input  logic [num_slots-1:0]                        slot_is_mem,
    input  logic [num_slots-1:0]                        slot_wb,
    input  logic [1:0]                                  inp_size,
    input  logic [3:0]                                  mem_size_ovr,  // one-hot
    input  logic                                        far_xfer,
    output logic [num_slots-1:0][data_w-1:0]            res,
    output logic [1:0]                                  ressize,
    output logic [3*num_slots-1:0]                      reg_addr,
    output logic [3*num_slots-1:0]                      seg_addr,
    output logic [num_slots-1:0]                        reg_cand,
    output logic [num_slots-1:0]                        seg_cand,
    output logic [num_slots-1:0]                        mem_sel,
    output logic [data_w-1:0]                           mem_data,
    output logic [wb_pkg::wb_addr_w-1:0]                mem_addr,
    output logic [1:0]                                  memsize
);

    import wb_pkg::*;

    // cs selector field inside a far pointer
    localparam int sel_lsb = 32;
    localparam int sel_w   = 16;

    logic [1:0] ovr_size;
    logic       ovr_any;

    // slot 0 shrinks to the selector on a far eip/cs load
    always_comb begin
        res = slot_data;
        if (far_xfer) begin
            res[0] = {{(data_w-sel_w){1'b0}}, slot_data[0][sel_lsb +: sel_w]};
        end
    end

    assign ressize = inp_size;

    // 3 bit register index per slot
    always_comb begin
        reg_addr = '0;
        seg_addr = '0;
        for (int i = 0; i < num_slots; i++) begin
            reg_addr[3*i +: 3] = slot_dest[i][2:0];
            seg_addr[3*i +: 3] = slot_dest[i][2:0];
        end
    end

    // ungated, commit adds valid_out
    assign reg_cand = slot_is_reg & slot_wb;
    assign seg_cand = slot_is_seg & slot_wb;
    assign mem_sel  = slot_is_mem & slot_wb;

    // lowest selected slot wins
    always_comb begin
        mem_data = '0;
        mem_addr = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (mem_sel[i]) begin
                mem_data = slot_data[i];
                mem_addr = slot_dest[i];
            end
        end
    end

    // size override decode
    assign ovr_any = |mem_size_ovr;

    always_comb begin
        if (mem_size_ovr[0]) begin
            ovr_size = msize_byte;
        end else if (mem_size_ovr[1]) begin
            ovr_size = msize_word;
        end else if (mem_size_ovr[2]) begin
            ovr_size = msize_dword;
        end else begin
            ovr_size = msize_qword;
        end
    end

    always_comb begin
        if (ovr_any) begin
            memsize = ovr_size;
        end else if (far_xfer) begin
            memsize = msize_dword;  // offset push is 32 bit
        end else begin
            memsize = inp_size;
        end
    end

endmodule

//--- writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
    parameter int num_slots = 4,
    parameter int data_w    = wb_pkg::wb_data_w
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        valid_in,
    input  logic [wb_pkg::wb_uop_w-1:0]                 uop_ctrl,
    input  logic [wb_pkg::wb_addr_w-1:0]                eip_in,
    input  logic [wb_pkg::wb_addr_w-1:0]                br_fip,
    input  logic [wb_pkg::wb_addr_w-1:0]                br_fip_p1,
    input  logic                                        br_taken,
    input  logic                                        br_correct,
    input  logic                                        ie_in,
    input  logic [3:0]                                  ie_type,
    input  logic                                        interrupt_in,
    input  logic                                        idtr_servicing,
    input  logic                                        instr_is_idtr_orig,
    input  logic                                        wbaq_full,
    input  logic [num_slots-1:0][data_w-1:0]            slot_data,
    input  logic [num_slots-1:0][wb_pkg::wb_addr_w-1:0] slot_dest,
    input  logic [num_slots-1:0]                        slot_is_reg,
    input  logic [num_slots-1:0]                        slot_is_seg,
    input  logic [num_slots-1:0]                        slot_is_mem,
    input  logic [num_slots-1:0]                        slot_wb,
    input  logic [1:0]                                  inp_size,
    input  logic [3:0]                                  mem_size_ovr,
    output logic                                        valid_out,
    output logic                                        stall,
    output logic                                        mem_ld,
    output logic [num_slots-1:0]                        reg_ld,
    output logic [num_slots-1:0]                        seg_ld,
    output logic [num_slots-1:0][data_w-1:0]            res,
    output logic [1:0]                                  ressize,
    output logic [3*num_slots-1:0]                      reg_addr,
    output logic [3*num_slots-1:0]                      seg_addr,
    output logic [data_w-1:0]                           mem_data,
    output logic [wb_pkg::wb_addr_w-1:0]                mem_addr,
    output logic [1:0]                                  memsize,
    output logic [wb_pkg::wb_addr_w-1:0]                new_fip_e,
    output logic [wb_pkg::wb_addr_w-1:0]                new_fip_o,
    output logic [wb_pkg::wb_addr_w-1:0]                new_eip,
    output logic                                        is_resteer,
    output logic                                        final_ie_val,
    output logic [3:0]                                  final_ie_type,
    output logic                                        instr_is_final_wb,
    output logic                                        halts,
    output logic                                        halt_flop
);

    import wb_pkg::*;

    logic                 far_xfer;
    logic                 halt_op;
    logic                 last_uop;
    logic                 idtr_last;
    logic                 ie_pending;
    logic [3:0]           ie_cause;
    logic [num_slots-1:0] reg_cand;
    logic [num_slots-1:0] seg_cand;
    logic [num_slots-1:0] mem_sel;

    wb_flow_ctrl i_flow (
        .uop_ctrl     (uop_ctrl),
        .valid_in     (valid_in),
        .eip_in       (eip_in),
        .br_fip       (br_fip),
        .br_fip_p1    (br_fip_p1),
        .br_taken     (br_taken),
        .br_correct   (br_correct),
        .slot0_low    (slot_data[0][wb_addr_w-1:0]),  // raw slot, not the selector
        .ie_in        (ie_in),
        .ie_type      (ie_type),
        .interrupt_in (interrupt_in),
        .valid_out    (valid_out),
        .far_xfer     (far_xfer),
        .halt_op      (halt_op),
        .last_uop     (last_uop),
        .idtr_last    (idtr_last),
        .new_fip_e    (new_fip_e),
        .new_fip_o    (new_fip_o),
        .new_eip      (new_eip),
        .is_resteer   (is_resteer),
        .ie_pending   (ie_pending),
        .ie_cause     (ie_cause)
    );

    wb_result_router #(
        .num_slots (num_slots),
        .data_w    (data_w)
    ) i_router (
        .slot_data    (slot_data),
        .slot_dest    (slot_dest),
        .slot_is_reg  (slot_is_reg),
        .slot_is_seg  (slot_is_seg),
        .slot_is_mem  (slot_is_mem),
        .slot_wb      (slot_wb),
        .inp_size     (inp_size),
        .mem_size_ovr (mem_size_ovr),
        .far_xfer     (far_xfer),
        .res          (res),
        .ressize      (ressize),
        .reg_addr     (reg_addr),
        .seg_addr     (seg_addr),
        .reg_cand     (reg_cand),
        .seg_cand     (seg_cand),
        .mem_sel      (mem_sel),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .memsize      (memsize)
    );

    wb_commit #(
        .num_slots (num_slots)
    ) i_commit (
        .clk                (clk),
        .reset              (reset),
        .valid_in           (valid_in),
        .wbaq_full          (wbaq_full),
        .instr_is_idtr_orig (instr_is_idtr_orig),
        .idtr_servicing     (idtr_servicing),
        .reg_cand           (reg_cand),
        .seg_cand           (seg_cand),
        .mem_sel            (mem_sel),
        .ie_pending         (ie_pending),
        .ie_cause           (ie_cause),
        .halt_op            (halt_op),
        .last_uop           (last_uop),
        .idtr_last          (idtr_last),
        .valid_out          (valid_out),
        .stall              (stall),
        .mem_ld             (mem_ld),
        .reg_ld             (reg_ld),
        .seg_ld             (seg_ld),
        .final_ie_val       (final_ie_val),
        .final_ie_type      (final_ie_type),
        .instr_is_final_wb  (instr_is_final_wb),
        .halts              (halts),
        .halt_flop          (halt_flop)
    );

endmodule
